// File: logic/issue_pkg.sv
/* shared types and widths for the scoreboard issue stage
   imported by the status rows, arbiter, register file and top level */
package issue_pkg;

    // architectural register file
    localparam int REG_COUNT = 32;
    localparam int REG_IDX_W = $clog2(REG_COUNT);

    // producer tag width, which caps the number of functional units at 7
    localparam int TAG_W = 3;

    localparam int STATE_W = 2;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // zero means the operand is ready, value k waits on unit k-1
    typedef logic [TAG_W-1:0] tag_t;

    // status row life cycle
    //  EMPTY  free for dispatch
    //  WAIT   loaded, operands may still be pending
    //  RDY    operands ready but passed over by the arbiter
    //  EX     issued, waiting for writeback
    typedef enum logic [STATE_W-1:0] {
        EMPTY = 2'd0,
        WAIT  = 2'd1,
        RDY   = 2'd2,
        EX    = 2'd3
    } fust_state_e;

endpackage

// File: logic/fu_status_row.sv
`timescale 1ns/10ps
/* status row of one functional unit; holds the dispatched instruction, its
   source tags and its age from dispatch until writeback frees the row */
module fu_status_row
    import issue_pkg::*;
#(
    parameter int AGE_W = 3
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             load,
    input  reg_idx_t         load_rd,
    input  reg_idx_t         load_rs1,
    input  reg_idx_t         load_rs2,
    input  tag_t             load_tag1,
    input  tag_t             load_tag2,
    input  logic             grant,
    input  logic             finish,
    input  tag_t             clear_tag,
    input  logic             clear_en,
    output logic             busy,
    output logic             ready,
    output logic [AGE_W-1:0] age,
    output reg_idx_t         rd,
    output reg_idx_t         rs1,
    output reg_idx_t         rs2
);

    localparam logic [AGE_W-1:0] AGE_MAX = '1;

    fust_state_e      state;
    fust_state_e      next_state;
    tag_t             tag1;
    tag_t             tag2;
    tag_t             next_tag1;
    tag_t             next_tag2;
    logic [AGE_W-1:0] next_age;
    logic             waiting;

    assign waiting = (state == WAIT) || (state == RDY);
    assign busy    = (state != EMPTY);
    assign ready   = waiting && (tag1 == '0) && (tag2 == '0);

    // a writeback in the dispatch cycle also clears the incoming tags
    always_comb begin
        next_tag1 = load ? load_tag1 : tag1;
        next_tag2 = load ? load_tag2 : tag2;
        if (clear_en && (next_tag1 == clear_tag)) begin
            next_tag1 = '0;
        end
        if (clear_en && (next_tag2 == clear_tag)) begin
            next_tag2 = '0;
        end
    end

    always_comb begin
        next_state = state;
        next_age   = age;
        case (state)
            EMPTY: begin
                if (load) begin
                    next_state = WAIT;
                    next_age   = AGE_W'(1);
                end
            end
            WAIT, RDY: begin
                if (grant) begin
                    next_state = EX;
                end else if (ready) begin
                    next_state = RDY;
                end
                // saturate so a long wait never wraps to young
                if (age != AGE_MAX) begin
                    next_age = age + 1'b1;
                end
            end
            EX: begin
                if (finish) begin
                    next_state = EMPTY;
                    next_age   = '0;
                end
            end
            default: next_state = EMPTY;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= EMPTY;
            tag1  <= '0;
            tag2  <= '0;
            age   <= '0;
        end else begin
            state <= next_state;
            tag1  <= next_tag1;
            tag2  <= next_tag2;
            age   <= next_age;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd  <= '0;
            rs1 <= '0;
            rs2 <= '0;
        end else if (load) begin
            rd  <= load_rd;
            rs1 <= load_rs1;
            rs2 <= load_rs2;
        end
    end

    // the arbiter only picks rows that report ready
    grant_needs_ready: assert property (@(posedge CLK) disable iff (!nRST)
        grant |-> ready)
        else $error("status row granted while not ready");

    // writeback must come from a unit that was issued
    finish_needs_ex: assert property (@(posedge CLK) disable iff (!nRST)
        finish |-> (state == EX))
        else $error("status row finished while not executing");

endmodule

// File: logic/oldest_ready_arbiter.sv
`timescale 1ns/10ps
/* picks the oldest ready status row for issue with ties going to the lowest index;
   the grant is one-hot and drops to zero while frozen */
module oldest_ready_arbiter #(
    parameter int NUM_FU = 4,
    parameter int AGE_W  = 3
) (
    input  logic [NUM_FU-1:0]            ready,
    input  logic [NUM_FU-1:0][AGE_W-1:0] ages,
    input  logic                         freeze,
    output logic [NUM_FU-1:0]            grant
);

    localparam int IDX_W = (NUM_FU > 1) ? $clog2(NUM_FU) : 1;

    logic             found;
    logic [IDX_W-1:0] best_idx;
    logic [AGE_W-1:0] best_age;

    // strictly greater keeps the lower index on equal ages
    always_comb begin
        found    = 1'b0;
        best_idx = '0;
        best_age = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (ready[i] && (!found || (ages[i] > best_age))) begin
                found    = 1'b1;
                best_idx = IDX_W'(i);
                best_age = ages[i];
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found && !freeze) begin
            grant[best_idx] = 1'b1;
        end
    end

endmodule

// File: logic/register_file.sv
`timescale 1ns/10ps
/* architectural register file with two combinational read ports and one
   write port; register zero is hardwired to zero */
module register_file
    import issue_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              wen,
    input  reg_idx_t          wsel,
    input  logic [DATA_W-1:0] wdata,
    input  reg_idx_t          rsel1,
    input  reg_idx_t          rsel2,
    output logic [DATA_W-1:0] rdat1,
    output logic [DATA_W-1:0] rdat2
);

    logic [DATA_W-1:0] regs [REG_COUNT];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wsel != '0)) begin
            regs[wsel] <= wdata;
        end
    end

    // no bypass; a reader released by a writeback reads one cycle later
    always_comb begin
        rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
        rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];
    end

endmodule

// File: logic/issue_stage.sv
`timescale 1ns/10ps
/* scoreboard issue stage with one status row per functional unit, oldest-ready
   arbitration onto the shared register file reads and registered issue outputs */
module issue_stage
    import issue_pkg::*;
#(
    parameter int NUM_FU = 4,
    parameter int DATA_W = 32,
    parameter int AGE_W  = 3
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      dispatch_valid,
    input  logic [$clog2(NUM_FU)-1:0] dispatch_fu,
    input  reg_idx_t                  dispatch_rd,
    input  reg_idx_t                  dispatch_rs1,
    input  reg_idx_t                  dispatch_rs2,
    input  tag_t                      dispatch_tag1,
    input  tag_t                      dispatch_tag2,
    output logic                      dispatch_ready,
    input  logic                      wb_valid,
    input  logic [$clog2(NUM_FU)-1:0] wb_fu,
    input  reg_idx_t                  wb_rd,
    input  logic [DATA_W-1:0]         wb_data,
    input  logic                      freeze,
    output logic                      issue_valid,
    output logic [$clog2(NUM_FU)-1:0] issue_fu,
    output reg_idx_t                  issue_rd,
    output logic [DATA_W-1:0]         issue_rdat1,
    output logic [DATA_W-1:0]         issue_rdat2
);

    localparam int FU_W = $clog2(NUM_FU);

    logic [NUM_FU-1:0]            load;
    logic [NUM_FU-1:0]            finish;
    logic [NUM_FU-1:0]            busy;
    logic [NUM_FU-1:0]            ready;
    logic [NUM_FU-1:0]            grant;
    logic [NUM_FU-1:0][AGE_W-1:0] row_age;
    reg_idx_t                     row_rd  [NUM_FU];
    reg_idx_t                     row_rs1 [NUM_FU];
    reg_idx_t                     row_rs2 [NUM_FU];
    tag_t                         wb_tag;
    logic [FU_W-1:0]              grant_fu;
    reg_idx_t                     sel_rd;
    reg_idx_t                     sel_rs1;
    reg_idx_t                     sel_rs2;
    logic [DATA_W-1:0]            rdat1;
    logic [DATA_W-1:0]            rdat2;

    // unit numbers beyond NUM_FU never accept a dispatch
    assign dispatch_ready = (int'(dispatch_fu) < NUM_FU) && !busy[dispatch_fu];

    // writeback from unit k releases operands tagged k+1
    assign wb_tag = tag_t'(wb_fu) + tag_t'(1);

    for (genvar i = 0; i < NUM_FU; i++) begin : g_row
        assign load[i]   = dispatch_valid && dispatch_ready && (dispatch_fu == FU_W'(i));
        assign finish[i] = wb_valid && (wb_fu == FU_W'(i));

        fu_status_row #(
            .AGE_W (AGE_W)
        ) row_inst (
            .CLK       (CLK),
            .nRST      (nRST),
            .load      (load[i]),
            .load_rd   (dispatch_rd),
            .load_rs1  (dispatch_rs1),
            .load_rs2  (dispatch_rs2),
            .load_tag1 (dispatch_tag1),
            .load_tag2 (dispatch_tag2),
            .grant     (grant[i]),
            .finish    (finish[i]),
            .clear_tag (wb_tag),
            .clear_en  (wb_valid),
            .busy      (busy[i]),
            .ready     (ready[i]),
            .age       (row_age[i]),
            .rd        (row_rd[i]),
            .rs1       (row_rs1[i]),
            .rs2       (row_rs2[i])
        );
    end

    oldest_ready_arbiter #(
        .NUM_FU (NUM_FU),
        .AGE_W  (AGE_W)
    ) arbiter_inst (
        .ready  (ready),
        .ages   (row_age),
        .freeze (freeze),
        .grant  (grant)
    );

    // the one-hot grant lets the granted row win the mux
    always_comb begin
        grant_fu = '0;
        sel_rd   = '0;
        sel_rs1  = '0;
        sel_rs2  = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (grant[i]) begin
                grant_fu = FU_W'(i);
                sel_rd   = row_rd[i];
                sel_rs1  = row_rs1[i];
                sel_rs2  = row_rs2[i];
            end
        end
    end

    register_file #(
        .DATA_W (DATA_W)
    ) regfile_inst (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (wb_valid),
        .wsel  (wb_rd),
        .wdata (wb_data),
        .rsel1 (sel_rs1),
        .rsel2 (sel_rs2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    // issue register held as a whole while execute is frozen
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            issue_valid <= 1'b0;
            issue_fu    <= '0;
            issue_rd    <= '0;
            issue_rdat1 <= '0;
            issue_rdat2 <= '0;
        end else if (!freeze) begin
            issue_valid <= |grant;
            if (|grant) begin
                issue_fu    <= grant_fu;
                issue_rd    <= sel_rd;
                issue_rdat1 <= rdat1;
                issue_rdat2 <= rdat2;
            end
        end
    end

    // an accepted dispatch holds its row from the next cycle
    dispatch_fills_row: assert property (@(posedge CLK) disable iff (!nRST)
        (dispatch_valid && dispatch_ready) |=> busy[$past(dispatch_fu)])
        else $error("dispatched row not busy after transfer");

endmodule

// File: test/issue_stage_tb.sv
`timescale 1ns/10ps
/* testbench for the scoreboard issue stage; a reference model tracks rows,
   tags and registers, and concurrent assertions compare the DUT with it */
module issue_stage_tb
    import issue_pkg::*;
();

    localparam int NUM_FU  = 4;
    localparam int DATA_W  = 32;
    localparam int AGE_W   = 3;
    localparam int FU_W    = $clog2(NUM_FU);
    localparam int AGE_MAX = (1 << AGE_W) - 1;

    logic              CLK;
    logic              nRST;
    logic              dispatch_valid;
    logic [FU_W-1:0]   dispatch_fu;
    reg_idx_t          dispatch_rd;
    reg_idx_t          dispatch_rs1;
    reg_idx_t          dispatch_rs2;
    tag_t              dispatch_tag1;
    tag_t              dispatch_tag2;
    logic              dispatch_ready;
    logic              wb_valid;
    logic [FU_W-1:0]   wb_fu;
    reg_idx_t          wb_rd;
    logic [DATA_W-1:0] wb_data;
    logic              freeze;
    logic              issue_valid;
    logic [FU_W-1:0]   issue_fu;
    reg_idx_t          issue_rd;
    logic [DATA_W-1:0] issue_rdat1;
    logic [DATA_W-1:0] issue_rdat2;

    // reference model
    logic              m_busy     [NUM_FU];
    logic              m_issued   [NUM_FU];
    tag_t              m_tag1     [NUM_FU];
    tag_t              m_tag2     [NUM_FU];
    reg_idx_t          m_rd       [NUM_FU];
    reg_idx_t          m_rs1      [NUM_FU];
    reg_idx_t          m_rs2      [NUM_FU];
    int                m_load_cyc [NUM_FU];
    logic [DATA_W-1:0] m_regs     [REG_COUNT];
    int                cyc;
    logic              g_found;
    int                g_idx;
    logic              exp_valid;
    logic [FU_W-1:0]   exp_fu;
    reg_idx_t          exp_rd;
    logic [DATA_W-1:0] exp_rdat1;
    logic [DATA_W-1:0] exp_rdat2;
    logic              exp_dispatch_ready;

    issue_stage #(
        .NUM_FU (NUM_FU),
        .DATA_W (DATA_W),
        .AGE_W  (AGE_W)
    ) issue_stage_inst (
        .CLK            (CLK),
        .nRST           (nRST),
        .dispatch_valid (dispatch_valid),
        .dispatch_fu    (dispatch_fu),
        .dispatch_rd    (dispatch_rd),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_tag1  (dispatch_tag1),
        .dispatch_tag2  (dispatch_tag2),
        .dispatch_ready (dispatch_ready),
        .wb_valid       (wb_valid),
        .wb_fu          (wb_fu),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .freeze         (freeze),
        .issue_valid    (issue_valid),
        .issue_fu       (issue_fu),
        .issue_rd       (issue_rd),
        .issue_rdat1    (issue_rdat1),
        .issue_rdat2    (issue_rdat2)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic report_failure(string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(string name, logic [DATA_W-1:0] got,
                                   logic [DATA_W-1:0] expected);
        report_failure($sformatf("Fail %0t %s got 0x%0h expected 0x%0h",
                                 $time, name, got, expected));
    endtask

    // oldest waiting row with clear tags and ties to the lowest unit
    always_comb begin : model_arbiter
        int age;
        int best;
        g_found = 1'b0;
        g_idx   = 0;
        best    = 0;
        for (int i = NUM_FU - 1; i >= 0; i--) begin
            age = (cyc - m_load_cyc[i] > AGE_MAX) ? AGE_MAX : cyc - m_load_cyc[i];
            if (m_busy[i] && !m_issued[i] && (m_tag1[i] == '0) && (m_tag2[i] == '0)
                    && (age >= best)) begin
                g_found = 1'b1;
                g_idx   = i;
                best    = age;
            end
        end
        if (freeze) begin
            g_found = 1'b0;
        end
    end

    assign exp_dispatch_ready = !m_busy[dispatch_fu];

    always @(posedge CLK or negedge nRST) begin : model_update
        tag_t wb_tag;
        tag_t t1;
        tag_t t2;
        if (!nRST) begin
            for (int i = 0; i < NUM_FU; i++) begin
                m_busy[i]   <= 1'b0;
                m_issued[i] <= 1'b0;
                m_tag1[i]   <= '0;
                m_tag2[i]   <= '0;
            end
            for (int r = 0; r < REG_COUNT; r++) begin
                m_regs[r] <= '0;
            end
            cyc       <= 0;
            exp_valid <= 1'b0;
            exp_fu    <= '0;
            exp_rd    <= '0;
            exp_rdat1 <= '0;
            exp_rdat2 <= '0;
        end else begin
            wb_tag = 3'(int'(wb_fu) + 1);
            cyc   <= cyc + 1;
            for (int i = 0; i < NUM_FU; i++) begin
                t1 = m_tag1[i];
                t2 = m_tag2[i];
                if (dispatch_valid && !m_busy[i] && (int'(dispatch_fu) == i)) begin
                    t1 = dispatch_tag1;
                    t2 = dispatch_tag2;
                    m_busy[i]     <= 1'b1;
                    m_issued[i]   <= 1'b0;
                    m_rd[i]       <= dispatch_rd;
                    m_rs1[i]      <= dispatch_rs1;
                    m_rs2[i]      <= dispatch_rs2;
                    m_load_cyc[i] <= cyc;
                end
                if (wb_valid && (t1 == wb_tag)) begin
                    t1 = '0;
                end
                if (wb_valid && (t2 == wb_tag)) begin
                    t2 = '0;
                end
                m_tag1[i] <= t1;
                m_tag2[i] <= t2;
                if (wb_valid && (int'(wb_fu) == i)) begin
                    m_busy[i]   <= 1'b0;
                    m_issued[i] <= 1'b0;
                end
            end
            if (wb_valid && (wb_rd != '0)) begin
                m_regs[wb_rd] <= wb_data;
            end
            // operands come from the registers as they were before this edge
            if (!freeze) begin
                exp_valid <= g_found;
                if (g_found) begin
                    m_issued[g_idx] <= 1'b1;
                    exp_fu          <= FU_W'(g_idx);
                    exp_rd          <= m_rd[g_idx];
                    exp_rdat1       <= m_regs[m_rs1[g_idx]];
                    exp_rdat2       <= m_regs[m_rs2[g_idx]];
                end
            end
        end
    end

    check_issue_valid: assert property (@(posedge CLK) disable iff (!nRST)
        issue_valid == exp_valid)
        else report_mismatch("issue_valid", DATA_W'($sampled(issue_valid)),
                             DATA_W'($sampled(exp_valid)));

    check_issue_fu: assert property (@(posedge CLK) disable iff (!nRST)
        issue_valid |-> (issue_fu == exp_fu))
        else report_mismatch("issue_fu", DATA_W'($sampled(issue_fu)),
                             DATA_W'($sampled(exp_fu)));

    check_issue_rd: assert property (@(posedge CLK) disable iff (!nRST)
        issue_valid |-> (issue_rd == exp_rd))
        else report_mismatch("issue_rd", DATA_W'($sampled(issue_rd)),
                             DATA_W'($sampled(exp_rd)));

    check_issue_rdat1: assert property (@(posedge CLK) disable iff (!nRST)
        issue_valid |-> (issue_rdat1 == exp_rdat1))
        else report_mismatch("issue_rdat1", $sampled(issue_rdat1), $sampled(exp_rdat1));

    check_issue_rdat2: assert property (@(posedge CLK) disable iff (!nRST)
        issue_valid |-> (issue_rdat2 == exp_rdat2))
        else report_mismatch("issue_rdat2", $sampled(issue_rdat2), $sampled(exp_rdat2));

    check_dispatch_ready: assert property (@(posedge CLK) disable iff (!nRST)
        dispatch_ready == exp_dispatch_ready)
        else report_mismatch("dispatch_ready", DATA_W'($sampled(dispatch_ready)),
                             DATA_W'($sampled(exp_dispatch_ready)));

    task automatic drive_idle();
        dispatch_valid = 1'b0;
        dispatch_fu    = '0;
        dispatch_rd    = '0;
        dispatch_rs1   = '0;
        dispatch_rs2   = '0;
        dispatch_tag1  = '0;
        dispatch_tag2  = '0;
        wb_valid       = 1'b0;
        wb_fu          = '0;
        wb_rd          = '0;
        wb_data        = '0;
    endtask

    task automatic dispatch_op(int fu, int rd, int rs1, int rs2, int tag1, int tag2);
        bit done = 1'b0;
        for (int n = 0; n < 50 && !done; n++) begin
            if (!m_busy[fu]) begin
                dispatch_valid = 1'b1;
                dispatch_fu    = FU_W'(fu);
                dispatch_rd    = reg_idx_t'(rd);
                dispatch_rs1   = reg_idx_t'(rs1);
                dispatch_rs2   = reg_idx_t'(rs2);
                dispatch_tag1  = tag_t'(tag1);
                dispatch_tag2  = tag_t'(tag2);
                done           = 1'b1;
            end
            @(negedge CLK);
        end
        dispatch_valid = 1'b0;
        if (!done) begin
            report_failure($sformatf("timeout at %0t: unit %0d never freed", $time, fu));
        end
    endtask

    task automatic writeback_op(int fu, logic [DATA_W-1:0] data);
        bit done = 1'b0;
        for (int n = 0; n < 50 && !done; n++) begin
            if (m_issued[fu]) begin
                wb_valid = 1'b1;
                wb_fu    = FU_W'(fu);
                wb_rd    = m_rd[fu];
                wb_data  = data;
                done     = 1'b1;
            end
            @(negedge CLK);
        end
        wb_valid = 1'b0;
        if (!done) begin
            report_failure($sformatf("timeout at %0t: unit %0d never executed", $time, fu));
        end
    endtask

    task automatic wait_issue(int fu);
        bit seen = 1'b0;
        for (int n = 0; n < 50 && !seen; n++) begin
            @(negedge CLK);
            seen = issue_valid && (int'(issue_fu) == fu);
        end
        if (!seen) begin
            report_failure($sformatf("timeout at %0t: unit %0d never issued", $time, fu));
        end
    endtask

    function automatic bit rows_busy();
        bit any = 1'b0;
        for (int i = 0; i < NUM_FU; i++) begin
            any = any | m_busy[i];
        end
        return any;
    endfunction

    // only waits on occupied units so no row can wait forever
    function automatic tag_t random_tag(int self);
        int j = $urandom_range(NUM_FU - 1);
        if ((j != self) && m_busy[j] && ($urandom_range(1) == 1)) begin
            return tag_t'(j + 1);
        end
        return '0;
    endfunction

    initial begin : stimulus
        int fu;
        int wfu;
        void'($urandom(17));
        drive_idle();
        freeze = 1'b0;
        nRST   = 1'b0;
        repeat (10) @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);

        // ready operands write r5 and a second op reads it back with r0
        dispatch_op(0, 5, 0, 0, 0, 0);
        wait_issue(0);
        writeback_op(0, $urandom());
        dispatch_op(1, 6, 5, 0, 0, 0);
        wait_issue(1);
        writeback_op(1, $urandom());

        // unit 1 waits on unit 2 until its writeback
        dispatch_op(2, 7, 5, 6, 0, 0);
        wait_issue(2);
        dispatch_op(1, 8, 7, 0, 3, 0);
        repeat (5) @(negedge CLK);
        writeback_op(2, $urandom());
        wait_issue(1);
        writeback_op(1, $urandom());

        // one writeback releases two rows and the older issues first
        dispatch_op(0, 9, 0, 0, 0, 0);
        wait_issue(0);
        dispatch_op(3, 10, 9, 0, 1, 0);
        dispatch_op(1, 11, 0, 9, 0, 1);
        writeback_op(0, $urandom());
        wait_issue(3);
        wait_issue(1);
        writeback_op(3, $urandom());
        writeback_op(1, $urandom());

        // saturated ages tie and the lower unit wins
        dispatch_op(0, 12, 0, 0, 0, 0);
        wait_issue(0);
        dispatch_op(3, 13, 12, 0, 1, 0);
        dispatch_op(1, 14, 12, 9, 1, 0);
        repeat (10) @(negedge CLK);
        writeback_op(0, $urandom());
        wait_issue(1);
        wait_issue(3);
        writeback_op(1, $urandom());
        writeback_op(3, $urandom());

        // freeze holds the issue register while a new row waits
        dispatch_op(2, 15, 5, 6, 0, 0);
        wait_issue(2);
        freeze = 1'b1;
        dispatch_op(0, 16, 7, 0, 0, 0);
        repeat (6) @(negedge CLK);
        freeze = 1'b0;
        wait_issue(0);
        writeback_op(2, $urandom());
        writeback_op(0, $urandom());

        for (int n = 0; n < 400; n++) begin
            drive_idle();
            freeze = ($urandom_range(4) == 0);
            fu = $urandom_range(NUM_FU - 1);
            dispatch_fu = FU_W'(fu);
            if (!m_busy[fu] && ($urandom_range(1) == 1)) begin
                dispatch_valid = 1'b1;
                dispatch_rd    = reg_idx_t'($urandom_range(REG_COUNT - 1));
                dispatch_rs1   = reg_idx_t'($urandom_range(REG_COUNT - 1));
                dispatch_rs2   = reg_idx_t'($urandom_range(REG_COUNT - 1));
                dispatch_tag1  = random_tag(fu);
                dispatch_tag2  = random_tag(fu);
            end
            wfu = $urandom_range(NUM_FU - 1);
            if (m_issued[wfu] && ($urandom_range(2) == 0)) begin
                wb_valid = 1'b1;
                wb_fu    = FU_W'(wfu);
                wb_rd    = m_rd[wfu];
                wb_data  = $urandom();
            end
            @(negedge CLK);
        end

        // drain every row through writeback
        freeze = 1'b0;
        for (int n = 0; n < 200 && rows_busy(); n++) begin
            drive_idle();
            for (int i = 0; i < NUM_FU; i++) begin
                if (m_issued[i] && !wb_valid) begin
                    wb_valid = 1'b1;
                    wb_fu    = FU_W'(i);
                    wb_rd    = m_rd[i];
                    wb_data  = $urandom();
                end
            end
            @(negedge CLK);
        end
        drive_idle();
        if (rows_busy()) begin
            report_failure($sformatf("timeout at %0t: rows did not drain", $time));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: scoreboard_issue.f
logic/issue_pkg.sv
logic/fu_status_row.sv
logic/oldest_ready_arbiter.sv
logic/register_file.sv
logic/issue_stage.sv
test/issue_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the issue stage testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module issue_stage_tb -Mdir obj_dir -o issue_stage_sim \
    -f scoreboard_issue.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/issue_stage_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
